// ==== verification/evaluator_cases.txt ====
# name, then rows 0 to 14 (column 0 is the first character; b black, w white, . empty)
# last column is the expected score, black total minus white total
empty_board ............... ............... ............... ............... ............... ............... ............... ............... ............... ............... ............... ............... ............... ............... ............... 0
black_five ............... ............... ............... ............... ............... .......b....... .......b....... .......b....... .......b....... .......b....... ............... ............... ............... ............... ............... 1000000
white_five ............... ............... ............... ............... ............... .......w....... .......w....... .......w....... .......w....... .......w....... ............... ............... ............... ............... ............... -1000000
black_open_four ............... ............... ............... ............... ...b........... ...b........... ...b........... ...b........... ............... ............... ............... ............... ............... ............... ............... 100000
white_open_four ............... ............... ............... ............... ...w........... ...w........... ...w........... ...w........... ............... ............... ............... ............... ............... ............... ............... -100000
black_blocked_four_top ............... ............... ............... ............... ..w............ ..b............ ..b............ ..b............ ..b............ ............... ............... ............... ............... ............... ............... 10000
black_blocked_four_bottom ............... ............... ............... ............... ............... ..b............ ..b............ ..b............ ..b............ ..w............ ............... ............... ............... ............... ............... 10000
white_blocked_four_top ............... ............... ............... ............... ..b............ ..w............ ..w............ ..w............ ..w............ ............... ............... ............... ............... ............... ............... -10000
white_blocked_four_bottom ............... ............... ............... ............... ............... ..w............ ..w............ ..w............ ..w............ ..b............ ............... ............... ............... ............... ............... -10000
black_open_three ............... ............... ............... ............... ............... ............... ..........b.... ..........b.... ..........b.... ............... ............... ............... ............... ............... ............... 1000
white_open_three ............... ............... ............... ............... ............... ............... ..........w.... ..........w.... ..........w.... ............... ............... ............... ............... ............... ............... -1000
black_open_two ............... ............... ............... ............... ............... ............... ............... ....b.......... ....b.......... ............... ............... ............... ............... ............... ............... 100
white_open_two ............... ............... ............... ............... ............... ............... ............... ....w.......... ....w.......... ............... ............... ............... ............... ............... ............... -100
horizontal_five ............... ............... ............... ............... ............... ............... ............... ...bbbbb....... ............... ............... ............... ............... ............... ............... ............... 0
edge_four_bottom ............... ............... ............... ............... ............... ............... ............... ............... ............... ............... ............... ......b........ ......b........ ......b........ ......b........ 0
top_bottom_mix b.............. b.............. b.............. b.............. b.............. ............... ............... ............... ............... ..............w ..............w ..............w ..............w ............... ............... 900000
mixed_negative ............... ............... .....b...b..... .....b...b..... .....b......... ............... ............... ............... ............... ............... .w............. .w............. .w............. .w............. .w............. -998900
mixed_blocked ...w........... ...b........... ...b........... ...b........... ...b........... ............... ............... ............... ............... ............b.. ........w...b.. ........w...... ........w...... ............... ............... 9100
black_six ..b............ ..b............ ..b............ ..b............ ..b............ ..b............ ............... ............... ............... ............... ............... ............... ............... ............... ............... 2000000
three_open_threes ............... ............... ............... ............... ............... ............... ....bbb........ ....bbb........ ....bbb........ ............... ............... ............... ............... ............... ............... 3000
mixed_white_sum ............... .............b. .............b. .............b. ............... ............... ............... ............... ............... .......w....... .......w....... .......w....... .......w....... ............... ............... -99000

// ==== project.f ====
+incdir+src
src/gomoku_board_pkg.sv
src/gomoku_score_pkg.sv
src/stage_if.sv
src/board_loader.sv
src/column_pattern_counter.sv
src/score_accumulator.sv
src/gomoku_evaluator.sv
verification/tb_clock_gen.sv
verification/tb_gomoku_evaluator.sv

// ==== Bender.yml ====
package:
  name: gomoku_evaluator

sources:
  - include_dirs:
      - src
    files:
      - src/gomoku_board_pkg.sv
      - src/gomoku_score_pkg.sv
      - src/stage_if.sv
      - src/board_loader.sv
      - src/column_pattern_counter.sv
      - src/score_accumulator.sv
      - src/gomoku_evaluator.sv

  - target: simulation
    include_dirs:
      - src
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_gomoku_evaluator.sv

// ==== verification/tb_gomoku_evaluator.sv ====
`timescale 1ns/1ps

`include "gomoku_settings.svh"

module tb_gomoku_evaluator
    import gomoku_board_pkg::*;
    import gomoku_score_pkg::*;
();

    localparam int DONE_LATENCY = 17;
    localparam int BUSY_CYCLES  = 15;

    logic   i_clk;
    logic   i_rst_n;
    logic   i_start;
    board_t i_board;
    logic   o_busy;
    logic   o_done;
    score_t o_score;

    // Case table
    string  names[$];
    board_t boards[$];
    score_t expected[$];
    int     case_err[$];
    int     num_cases;

    // Cases waiting for their done pulse
    int     pend_idx[$];
    int     pend_edge[$];

    int     cycle       = 0;
    int     limit       = 200;
    int     last_accept = -100;
    int     cur_case    = -1;
    int     errors      = 0;
    int     passed      = 0;
    int     failed      = 0;
    score_t held_score  = '0;
    logic   running     = 1'b0;

    tb_clock_gen u_clock_gen (
        .o_clk   (i_clk),
        .o_rst_n (i_rst_n)
    );

    gomoku_evaluator UUT (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_board (i_board),
        .o_busy  (o_busy),
        .o_done  (o_done),
        .o_score (o_score)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic cell_t cell_from_char(input byte ch);
        if (ch == "b") return CELL_BLACK;
        if (ch == "w") return CELL_WHITE;
        return CELL_EMPTY;
    endfunction

    function automatic board_t random_board();
        board_t b;
        for (int c = 0; c < `BOARD_SIZE; c++) begin
            for (int r = 0; r < `BOARD_SIZE; r++) begin
                b[c][r] = cell_t'($urandom_range(0, 2));
            end
        end
        return b;
    endfunction

    function automatic board_t empty_board();
        board_t b;
        for (int c = 0; c < `BOARD_SIZE; c++) begin
            for (int r = 0; r < `BOARD_SIZE; r++) begin
                b[c][r] = CELL_EMPTY;
            end
        end
        return b;
    endfunction

    task automatic report_case(input int idx);
        if (case_err[idx] == 0) begin
            passed++;
            $display("PASS %s score %0d", names[idx], expected[idx]);
        end else begin
            failed++;
            $display("FAIL %s with %0d error(s)", names[idx], case_err[idx]);
        end
    endtask

    task automatic read_cases();
        int     fd;
        int     got;
        int     score_val;
        string  line;
        string  name;
        string  r [`BOARD_SIZE];
        board_t b;
        fd = $fopen("verification/evaluator_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") continue;
                got = $sscanf(line, "%s %s %s %s %s %s %s %s %s %s %s %s %s %s %s %s %d",
                              name, r[0], r[1], r[2], r[3], r[4], r[5], r[6], r[7],
                              r[8], r[9], r[10], r[11], r[12], r[13], r[14], score_val);
                if (got != 17) begin
                    $display("Malformed case line skipped: %s", line);
                    errors++;
                    continue;
                end
                // Rows in the file, columns in the board
                for (int row = 0; row < `BOARD_SIZE; row++) begin
                    for (int col = 0; col < `BOARD_SIZE; col++) begin
                        b[col][row] = cell_from_char(r[row][col]);
                    end
                end
                names.push_back(name);
                boards.push_back(b);
                expected.push_back(score_t'(score_val));
                case_err.push_back(0);
            end
            $fclose(fd);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cycle count and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge i_clk) begin
        cycle <= cycle + 1;
        if (cycle >= limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle);
            $display("Test failures found");
            $finish;
        end
    end

    // Output checks at the falling edge
    always @(negedge i_clk) begin
        int   e;
        int   idx;
        logic busy_exp;
        e = cycle - 1;     // Index of the rising edge just passed
        if (running) begin
            busy_exp = (e >= last_accept) && (e - last_accept < BUSY_CYCLES);
            assert (o_busy == busy_exp) else begin
                $display("MISMATCH %s o_busy at edge %0d expected %0b actual %0b",
                         (cur_case >= 0) ? names[cur_case] : "idle", e,
                         busy_exp, o_busy);
                errors++;
                if (cur_case >= 0) case_err[cur_case]++;
            end
            if (o_done) begin
                assert (pend_edge.size() > 0 && e == pend_edge[0] + DONE_LATENCY) else begin
                    $display("Done pulse at edge %0d that belongs to no started board", e);
                    errors++;
                end
                if (pend_edge.size() > 0 && e == pend_edge[0] + DONE_LATENCY) begin
                    idx = pend_idx.pop_front();
                    void'(pend_edge.pop_front());
                    assert (o_score == expected[idx]) else begin
                        $display("MISMATCH %s expected %0d actual %0d",
                                 names[idx], expected[idx], o_score);
                        errors++;
                        case_err[idx]++;
                    end
                    held_score = o_score;
                    report_case(idx);
                end
            end else begin
                assert (o_score == held_score) else begin
                    $display("Score changed without a done pulse at edge %0d", e);
                    errors++;
                    held_score = o_score;
                end
                if (pend_edge.size() > 0 && e >= pend_edge[0] + DONE_LATENCY) begin
                    idx = pend_idx.pop_front();
                    void'(pend_edge.pop_front());
                    assert (1'b0) else begin
                        $display("Done for %s did not arrive %0d cycles after start",
                                 names[idx], DONE_LATENCY);
                        errors++;
                        case_err[idx]++;
                    end
                    report_case(idx);
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        i_start = 1'b0;
        i_board = empty_board();
        void'($urandom(32'hac3c));
        read_cases();
        num_cases = names.size();
        limit = num_cases * 25 + 200;

        wait (i_rst_n === 1'b1);
        @(negedge i_clk);
        assert (o_busy == 1'b0 && o_done == 1'b0 && o_score == '0) else begin
            $display("MISMATCH reset expected busy 0 done 0 score 0 actual %0b %0b %0d",
                     o_busy, o_done, o_score);
            errors++;
        end
        running = 1'b1;
        @(posedge i_clk);

        for (int n = 0; n < num_cases; n++) begin
            int gap;
            gap = (n % 4 == 1) ? 0 : $urandom_range(0, 3);   // Some boards back to back
            repeat (gap) @(posedge i_clk);
            i_start <= 1'b1;
            i_board <= boards[n];
            @(posedge i_clk);               // Accepting edge
            last_accept = cycle;
            cur_case    = n;
            pend_idx.push_back(n);
            pend_edge.push_back(cycle);
            i_start <= 1'b0;
            repeat (3) @(posedge i_clk);
            // Start while busy and a new board, both ignored
            i_start <= 1'b1;
            i_board <= random_board();
            @(posedge i_clk);
            i_start <= 1'b0;
            repeat (11) @(posedge i_clk);
        end

        while (pend_idx.size() > 0) @(posedge i_clk);
        repeat (4) @(posedge i_clk);

        $display("Summary: %0d cases, %0d passed, %0d failed, %0d errors",
                 num_cases, passed, failed, errors);
        if (errors == 0 && failed == 0 && passed == num_cases && num_cases > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

// Free-running clock and power-on reset for the testbench
module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;     // 8 ns period
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (16) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

// ==== src/gomoku_evaluator.sv ====
`timescale 1ns/1ps

module gomoku_evaluator
    import gomoku_board_pkg::*;
    import gomoku_score_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_start,
    input  board_t i_board,
    output logic   o_busy,
    output logic   o_done,
    output score_t o_score
);

    // Loader to counter, one column per cycle
    stage_if #(.payload_t(column_t))         column_stream ();
    // Counter to accumulator
    stage_if #(.payload_t(pattern_counts_t)) count_stream ();

    board_loader u_board_loader (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (i_start),
        .i_board   (i_board),
        .o_busy    (o_busy),
        .o_columns (column_stream.src)
    );

    column_pattern_counter u_column_pattern_counter (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_columns (column_stream.dst),
        .o_counts  (count_stream.src)
    );

    score_accumulator u_score_accumulator (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_counts (count_stream.dst),
        .o_done   (o_done),
        .o_score  (o_score)
    );

endmodule

// ==== src/score_accumulator.sv ====
`timescale 1ns/1ps

`include "gomoku_settings.svh"

module score_accumulator
    import gomoku_score_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    stage_if.dst   i_counts,
    output logic   o_done,
    output score_t o_score
);

    logic [`TOTAL_WIDTH-1:0] black_total;
    logic [`TOTAL_WIDTH-1:0] white_total;
    logic [`TOTAL_WIDTH-1:0] black_sum;
    logic [`TOTAL_WIDTH-1:0] white_sum;
    logic                    board_end;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Weighting of one column
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [`TOTAL_WIDTH-1:0] weigh(input color_counts_t c);
        logic [`TOTAL_WIDTH-1:0] acc;
        acc = `TOTAL_WIDTH'(c.five) * `WEIGHT_FIVE;
        acc = acc + `TOTAL_WIDTH'(c.open_four) * `WEIGHT_OPEN_FOUR;
        acc = acc + `TOTAL_WIDTH'(c.blocked_four) * `WEIGHT_BLOCKED_FOUR;
        acc = acc + `TOTAL_WIDTH'(c.open_three) * `WEIGHT_OPEN_THREE;
        acc = acc + `TOTAL_WIDTH'(c.open_two) * `WEIGHT_OPEN_TWO;
        return acc;
    endfunction

    // First column restarts both totals
    always_comb begin
        if (i_counts.first) begin
            black_sum = weigh(i_counts.payload.black);
            white_sum = weigh(i_counts.payload.white);
        end else begin
            black_sum = black_total + weigh(i_counts.payload.black);
            white_sum = white_total + weigh(i_counts.payload.white);
        end
    end

    assign board_end = i_counts.valid && i_counts.last;

    always_ff @(posedge i_clk) begin
        if (i_counts.valid) begin
            black_total <= black_sum;
            white_total <= white_sum;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result and done pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_done  <= 1'b0;
            o_score <= '0;
        end else begin
            o_done <= board_end;
            if (board_end) begin
                o_score <= score_t'(black_sum - white_sum);   // Held until next board
            end
        end
    end

endmodule

// ==== src/column_pattern_counter.sv ====
`timescale 1ns/1ps

`include "gomoku_settings.svh"

module column_pattern_counter
    import gomoku_board_pkg::*;
    import gomoku_score_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    stage_if.dst i_columns,
    stage_if.src o_counts
);

    pattern_counts_t counts_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Window matching for one colour
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic color_counts_t count_color(
        input column_t col,
        input cell_t   own,
        input cell_t   opp
    );
        color_counts_t cnt;
        logic          core_three;
        logic          core_four;
        logic          edge_open;
        cnt = '0;

        // 5-cell windows
        for (int i = 0; i <= `BOARD_SIZE - `WINDOW_SHORT; i++) begin
            core_three = (col[i+1] == own) && (col[i+2] == own) && (col[i+3] == own);
            if (core_three && col[i] == own && col[i+4] == own) begin
                cnt.five = cnt.five + 1'b1;
            end
            if (core_three && col[i] == CELL_EMPTY && col[i+4] == CELL_EMPTY) begin
                cnt.open_three = cnt.open_three + 1'b1;
            end
        end

        // 6-cell windows
        for (int i = 0; i <= `BOARD_SIZE - `WINDOW_LONG; i++) begin
            core_four = (col[i+1] == own) && (col[i+2] == own)
                     && (col[i+3] == own) && (col[i+4] == own);
            edge_open = (col[i] == CELL_EMPTY) && (col[i+5] == CELL_EMPTY);
            if (core_four && edge_open) begin
                cnt.open_four = cnt.open_four + 1'b1;
            end
            // One end empty, the other held by the opponent
            if (core_four && ((col[i] == CELL_EMPTY && col[i+5] == opp) ||
                              (col[i] == opp && col[i+5] == CELL_EMPTY))) begin
                cnt.blocked_four = cnt.blocked_four + 1'b1;
            end
            if (edge_open && col[i+1] == CELL_EMPTY && col[i+2] == own
                    && col[i+3] == own && col[i+4] == CELL_EMPTY) begin
                cnt.open_two = cnt.open_two + 1'b1;
            end
        end
        return cnt;
    endfunction

    always_comb begin
        counts_next.black = count_color(i_columns.payload, CELL_BLACK, CELL_WHITE);
        counts_next.white = count_color(i_columns.payload, CELL_WHITE, CELL_BLACK);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_counts.valid <= 1'b0;
            o_counts.first <= 1'b0;
            o_counts.last  <= 1'b0;
        end else begin
            o_counts.valid <= i_columns.valid;
            o_counts.first <= i_columns.valid && i_columns.first;
            o_counts.last  <= i_columns.valid && i_columns.last;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_columns.valid) begin
            o_counts.payload <= counts_next;
        end
    end

endmodule

// ==== src/board_loader.sv ====
`timescale 1ns/1ps

`include "gomoku_settings.svh"

module board_loader
    import gomoku_board_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_start,
    input  board_t i_board,
    output logic   o_busy,
    stage_if.src   o_columns
);

    localparam int IDX_WIDTH = $clog2(`BOARD_SIZE);

    board_t               board_r;      // Snapshot taken on start
    logic [IDX_WIDTH-1:0] col_idx;
    logic                 busy_r;
    logic                 start_accept;
    logic                 last_col;

    assign start_accept = i_start && !busy_r;
    assign last_col     = (col_idx == IDX_WIDTH'(`BOARD_SIZE - 1));
    assign o_busy       = busy_r;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy_r          <= 1'b0;
            col_idx         <= '0;
            o_columns.valid <= 1'b0;
            o_columns.first <= 1'b0;
            o_columns.last  <= 1'b0;
        end else begin
            o_columns.valid <= busy_r;
            o_columns.first <= busy_r && (col_idx == '0);
            o_columns.last  <= busy_r && last_col;
            if (start_accept) begin
                busy_r  <= 1'b1;
                col_idx <= '0;
            end else if (busy_r) begin
                col_idx <= col_idx + 1'b1;
                if (last_col) begin
                    busy_r <= 1'b0;     // Free for the next start
                end
            end
        end
    end

    // Board snapshot and column output
    always_ff @(posedge i_clk) begin
        if (start_accept) begin
            board_r <= i_board;
        end
        if (busy_r) begin
            o_columns.payload <= board_r[col_idx];
        end
    end

endmodule

// ==== src/stage_if.sv ====
`timescale 1ns/1ps

// One item per cycle between pipeline stages, no back-pressure
interface stage_if #(
    parameter type payload_t = logic
) ();

    logic     valid;    // Item present this cycle
    logic     first;    // Column 0 of a board
    logic     last;     // Final column of a board
    payload_t payload;

    modport src (
        output valid,
        output first,
        output last,
        output payload
    );

    modport dst (
        input valid,
        input first,
        input last,
        input payload
    );

endinterface

// ==== src/gomoku_score_pkg.sv ====
package gomoku_score_pkg;

`include "gomoku_settings.svh"

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shape counts
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Counts for a single colour within one column
    typedef struct packed {
        logic [`COUNT_WIDTH-1:0] five;
        logic [`COUNT_WIDTH-1:0] open_four;
        logic [`COUNT_WIDTH-1:0] blocked_four;
        logic [`COUNT_WIDTH-1:0] open_three;
        logic [`COUNT_WIDTH-1:0] open_two;
    } color_counts_t;

    typedef struct packed {
        color_counts_t black;
        color_counts_t white;
    } pattern_counts_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Black total minus white total
    typedef logic signed [`SCORE_WIDTH-1:0] score_t;

endpackage

// ==== src/gomoku_board_pkg.sv ====
package gomoku_board_pkg;

`include "gomoku_settings.svh"

    // Cell codes of the board
    typedef enum logic [`CELL_WIDTH-1:0] {
        CELL_BLACK = 2'd0,
        CELL_WHITE = 2'd1,
        CELL_EMPTY = 2'd2
    } cell_t;

    // One column, row 0 at the top
    typedef cell_t [0:`BOARD_SIZE-1] column_t;

    // Whole board, column 0 first
    typedef column_t [0:`BOARD_SIZE-1] board_t;

endpackage

// ==== src/gomoku_settings.svh ====
`ifndef GOMOKU_SETTINGS_SVH
`define GOMOKU_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BOARD_SIZE          15
`define CELL_WIDTH          2
`define WINDOW_SHORT        5       // Five and open three
`define WINDOW_LONG         6       // Fours and open two

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define COUNT_WIDTH         4       // At most 11 windows per column
`define TOTAL_WIDTH         32
`define SCORE_WIDTH         32

// Shape weights
`define WEIGHT_FIVE         1000000
`define WEIGHT_OPEN_FOUR    100000
`define WEIGHT_BLOCKED_FOUR 10000
`define WEIGHT_OPEN_THREE   1000
`define WEIGHT_OPEN_TWO     100

`endif
